//--- hw/nn_alu.sv
`default_nettype none
`timescale 1ns/1ps

`include "nn_settings.svh"

module nn_alu (
    input  nn_pkg::data_t     op1,
    input  nn_pkg::data_t     shamt,
    input  nn_pkg::shift_op_t op,
    output nn_pkg::data_t     result,
    output logic              zero,
    output logic              ovf
);

    logic [`NN_SHAMT_W-1:0] sh;      // Effective shift distance
    nn_pkg::data_t          asr_res;
    nn_pkg::data_t          asl_res;
    nn_pkg::data_t          asl_back; // Left result shifted back right

    assign sh = shamt[`NN_SHAMT_W-1:0];

    assign asr_res  = op1 >>> sh;
    assign asl_res  = op1 <<< sh;
    assign asl_back = asl_res >>> sh;

    always_comb begin
        case (op)
            nn_pkg::OP_ASL: begin
                result = asl_res;
                // Lost bits or a sign change show up as a mismatch
                ovf    = (asl_back != op1);
            end
            default: begin
                result = asr_res;
                ovf    = 1'b0;           // Right shift cannot overflow
            end
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- hw/nn_decode.sv
`default_nettype none
`timescale 1ns/1ps

module nn_decode (
    input  logic           clk,
    input  logic           resetn,
    input  logic           enable,
    input  logic           stage_ovf,
    output nn_pkg::stage_t stage,
    output logic           out_step,
    output logic           start
);

    nn_pkg::stage_t stage_next;
    logic           step_next;
    logic           start_next;

    always_comb begin
        stage_next = stage;
        step_next  = 1'b0;
        start_next = 1'b0;
        case (stage)
            nn_pkg::STAGE_IDLE: begin
                if (enable) begin          // Level sampled only here
                    stage_next = nn_pkg::STAGE_PRE;
                    start_next = 1'b1;
                end
            end
            nn_pkg::STAGE_PRE:  stage_next = nn_pkg::STAGE_IN;
            nn_pkg::STAGE_IN:   stage_next = nn_pkg::STAGE_OUT;
            nn_pkg::STAGE_OUT: begin
                if (out_step) begin
                    stage_next = nn_pkg::STAGE_POST;
                end else begin
                    step_next = 1'b1;      // Second serial MAC next
                end
            end
            nn_pkg::STAGE_POST: stage_next = nn_pkg::STAGE_IDLE;
            default:            stage_next = nn_pkg::STAGE_IDLE;
        endcase

        // Abort on any overflow of the running stage
        if (stage_ovf) begin
            stage_next = nn_pkg::STAGE_IDLE;
            step_next  = 1'b0;
            start_next = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            stage    <= nn_pkg::STAGE_IDLE;
            out_step <= 1'b0;
            start    <= 1'b0;
        end else begin
            stage    <= stage_next;
            out_step <= step_next;
            start    <= start_next;   // High for the first PRE cycle only
        end
    end

    step_in_out: assert property (@(posedge clk) disable iff (!resetn)
        out_step |-> (stage == nn_pkg::STAGE_OUT))
        else $error("out_step set outside output layer");

    start_in_pre: assert property (@(posedge clk) disable iff (!resetn)
        start |-> (stage == nn_pkg::STAGE_PRE))
        else $error("start outside pre-processing");

endmodule

`default_nettype wire

//--- hw/nn_execute.sv
`default_nettype none
`timescale 1ns/1ps

`include "nn_settings.svh"

module nn_execute (
    input  logic           clk,
    input  logic           resetn,
    input  nn_pkg::stage_t stage,
    input  logic           out_step,
    input  nn_pkg::data_t  input_1,
    input  nn_pkg::data_t  input_2,
    output logic           stage_ovf,
    output logic           stage_zero,
    output nn_pkg::data_t  post_result
);

    nn_pkg::data_t inter_1, inter_2, inter_3, inter_4, inter_5;
    nn_pkg::data_t temp_result;            // First serial MAC of output layer

    nn_pkg::data_t     alu1_op1, alu1_shamt, alu1_res;
    nn_pkg::data_t     alu2_op1, alu2_shamt, alu2_res;
    nn_pkg::shift_op_t alu1_op;
    logic              alu1_zero, alu1_ovf, alu2_zero, alu2_ovf;

    nn_pkg::data_t mac1_op1, mac1_op2, mac1_op3, mac1_res;
    nn_pkg::data_t mac2_op1, mac2_op2, mac2_op3, mac2_res;
    logic          mac1_zm, mac1_za, mac1_om, mac1_oa;
    logic          mac2_zm, mac2_za, mac2_om, mac2_oa;

    always_comb begin
        alu1_op1 = '0;  alu1_shamt = '0;  alu1_op = nn_pkg::OP_ASR;
        alu2_op1 = '0;  alu2_shamt = '0;
        mac1_op1 = '0;  mac1_op2 = '0;  mac1_op3 = '0;
        mac2_op1 = '0;  mac2_op2 = '0;  mac2_op3 = '0;
        stage_ovf  = 1'b0;
        stage_zero = 1'b0;              // Idle raises nothing
        case (stage)
            nn_pkg::STAGE_PRE: begin
                alu1_op1 = input_1;  alu1_shamt = `NN_SHIFT_BIAS_1;
                alu2_op1 = input_2;  alu2_shamt = `NN_SHIFT_BIAS_2;
                stage_ovf  = alu1_ovf | alu2_ovf;
                stage_zero = alu1_zero | alu2_zero;
            end
            nn_pkg::STAGE_IN: begin
                mac1_op1 = inter_1;  mac1_op2 = `NN_WEIGHT_1;  mac1_op3 = `NN_BIAS_1;
                mac2_op1 = inter_2;  mac2_op2 = `NN_WEIGHT_2;  mac2_op3 = `NN_BIAS_2;
                stage_ovf  = mac1_om | mac1_oa | mac2_om | mac2_oa;
                stage_zero = mac1_zm | mac1_za | mac2_zm | mac2_za;
            end
            nn_pkg::STAGE_OUT: begin
                if (!out_step) begin        // Step 0 on MAC 1
                    mac1_op1 = inter_3;  mac1_op2 = `NN_WEIGHT_3;  mac1_op3 = `NN_BIAS_3;
                    stage_ovf  = mac1_om | mac1_oa;
                    stage_zero = mac1_zm | mac1_za;
                end else begin              // Step 1 accumulates step 0
                    mac2_op1 = inter_4;  mac2_op2 = `NN_WEIGHT_4;  mac2_op3 = temp_result;
                    stage_ovf  = mac2_om | mac2_oa;
                    stage_zero = mac2_zm | mac2_za;
                end
            end
            nn_pkg::STAGE_POST: begin
                alu1_op1 = inter_5;  alu1_shamt = `NN_SHIFT_BIAS_3;  alu1_op = nn_pkg::OP_ASL;
                stage_ovf  = alu1_ovf;
                stage_zero = alu1_zero;
            end
            default: ;
        endcase
    end

    assign post_result = alu1_res;       // Only meaningful in POST

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            inter_1 <= '0;  inter_2 <= '0;  inter_3 <= '0;
            inter_4 <= '0;  inter_5 <= '0;  temp_result <= '0;
        end else begin
            case (stage)
                nn_pkg::STAGE_PRE: begin
                    inter_1 <= alu1_res;
                    inter_2 <= alu2_res;
                end
                nn_pkg::STAGE_IN: begin
                    inter_3 <= mac1_res;
                    inter_4 <= mac2_res;
                end
                nn_pkg::STAGE_OUT: begin
                    if (!out_step) temp_result <= mac1_res;
                    else           inter_5     <= mac2_res;
                end
                default: ;
            endcase
        end
    end

    nn_alu u_alu_1 (.op1(alu1_op1), .shamt(alu1_shamt), .op(alu1_op),
        .result(alu1_res), .zero(alu1_zero), .ovf(alu1_ovf));
    nn_alu u_alu_2 (.op1(alu2_op1), .shamt(alu2_shamt), .op(nn_pkg::OP_ASR),
        .result(alu2_res), .zero(alu2_zero), .ovf(alu2_ovf));

    nn_mac u_mac_1 (.op1(mac1_op1), .op2(mac1_op2), .op3(mac1_op3), .total_result(mac1_res),
        .zero_mul(mac1_zm), .zero_add(mac1_za), .ovf_mul(mac1_om), .ovf_add(mac1_oa));
    nn_mac u_mac_2 (.op1(mac2_op1), .op2(mac2_op2), .op3(mac2_op3), .total_result(mac2_res),
        .zero_mul(mac2_zm), .zero_add(mac2_za), .ovf_mul(mac2_om), .ovf_add(mac2_oa));

endmodule

`default_nettype wire

//--- hw/nn_mac.sv
`default_nettype none
`timescale 1ns/1ps

`include "nn_settings.svh"

module nn_mac (
    input  nn_pkg::data_t op1,
    input  nn_pkg::data_t op2,
    input  nn_pkg::data_t op3,
    output nn_pkg::data_t total_result,
    output logic          zero_mul,
    output logic          zero_add,
    output logic          ovf_mul,
    output logic          ovf_add
);

    localparam int W = `NN_DATA_W;

    logic signed [2*W-1:0] full_prod;  // Exact product
    nn_pkg::data_t         mul_lo;     // Truncated product

    assign full_prod = op1 * op2;
    assign mul_lo    = full_prod[W-1:0];

    // Upper half must be a pure sign extension of the low word
    assign ovf_mul = (full_prod[2*W-1:W-1] != {(W+1){full_prod[W-1]}});
    assign zero_mul = (mul_lo == '0);

    assign total_result = mul_lo + op3;

    // Same operand signs, different result sign
    assign ovf_add  = (mul_lo[W-1] == op3[W-1]) && (total_result[W-1] != mul_lo[W-1]);
    assign zero_add = (total_result == '0);

    always_comb begin
        if (!$isunknown(op1)) begin
            flags_known: assert final (!$isunknown({zero_mul, zero_add, ovf_mul, ovf_add}))
                else $error("MAC flag unknown with known op1");
        end
    end

endmodule

`default_nettype wire

//--- hw/nn_pkg.sv
`default_nettype none

`include "nn_settings.svh"

package nn_pkg;

    // Signed data word of the whole datapath
    typedef logic signed [`NN_DATA_W-1:0] data_t;

    // Sequencer stages, encoded as the reported stage codes
    typedef enum logic [2:0] {
        STAGE_IDLE = `NN_STAGE_NONE,
        STAGE_PRE  = `NN_STAGE_PRE,   // Input shifts
        STAGE_IN   = `NN_STAGE_IN,    // Two parallel MACs
        STAGE_OUT  = `NN_STAGE_OUT,   // Two serial MACs
        STAGE_POST = `NN_STAGE_POST   // Output shift
    } stage_t;

    // Shift unit operations
    typedef enum logic {
        OP_ASR = 1'b0,                // Arithmetic right
        OP_ASL = 1'b1                 // Arithmetic left
    } shift_op_t;

endpackage

`default_nettype wire

//--- hw/nn_result.sv
`default_nettype none
`timescale 1ns/1ps

`include "nn_settings.svh"

module nn_result (
    input  logic           clk,
    input  logic           resetn,
    input  nn_pkg::stage_t stage,
    input  logic           start,
    input  logic           stage_ovf,
    input  logic           stage_zero,
    input  nn_pkg::data_t  post_result,
    output nn_pkg::data_t  final_output,
    output logic           total_ovf,
    output logic           total_zero,
    output logic [2:0]     ovf_fsm_stage,
    output logic [2:0]     zero_fsm_stage
);

    // Flag state seen by this cycle, cleared on the first cycle of a run
    logic       base_ovf, base_zero;
    logic [2:0] base_ovf_stage, base_zero_stage;
    logic [2:0] stage_code;

    assign stage_code = stage;       // Enum encodings are the stage codes

    assign base_ovf        = start ? 1'b0           : total_ovf;
    assign base_zero       = start ? 1'b0           : total_zero;
    assign base_ovf_stage  = start ? `NN_STAGE_NONE : ovf_fsm_stage;
    assign base_zero_stage = start ? `NN_STAGE_NONE : zero_fsm_stage;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            final_output   <= '0;
            total_ovf      <= 1'b0;
            total_zero     <= 1'b0;
            ovf_fsm_stage  <= `NN_STAGE_NONE;
            zero_fsm_stage <= `NN_STAGE_NONE;
        end else begin
            total_ovf      <= base_ovf | stage_ovf;
            total_zero     <= base_zero | stage_zero;
            // First flagging stage wins
            ovf_fsm_stage  <= (stage_ovf && !base_ovf) ? stage_code : base_ovf_stage;
            zero_fsm_stage <= (stage_zero && !base_zero) ? stage_code : base_zero_stage;

            if (stage_ovf) begin
                final_output <= '1;      // Aborted run reads as all ones
            end else if (stage == nn_pkg::STAGE_POST) begin
                final_output <= post_result;
            end
        end
    end

    ovf_stage_sticky: assert property (@(posedge clk) disable iff (!resetn)
        (ovf_fsm_stage != `NN_STAGE_NONE) |-> total_ovf)
        else $error("Overflow stage recorded without total_ovf");

endmodule

`default_nettype wire

//--- hw/nn_settings.svh
`ifndef NN_SETTINGS_SVH
`define NN_SETTINGS_SVH

// Datapath widths
`define NN_DATA_W  32
`define NN_SHAMT_W 5              // Shift amount taken from low bits of a bias

// Shift constants
`define NN_SHIFT_BIAS_1 32'sd1    // Pre-processing, input_1
`define NN_SHIFT_BIAS_2 32'sd2    // Pre-processing, input_2
`define NN_SHIFT_BIAS_3 32'sd1    // Post-processing left shift

// Layer coefficients
`define NN_WEIGHT_1 32'sd3
`define NN_WEIGHT_2 32'sd5
`define NN_WEIGHT_3 32'sd2
`define NN_WEIGHT_4 32'sd4
`define NN_BIAS_1   32'sd7
`define NN_BIAS_2   (-32'sd3)
`define NN_BIAS_3   32'sd11

// Stage codes, also reported on the flag stage outputs
`define NN_STAGE_PRE  3'd3
`define NN_STAGE_IN   3'd4
`define NN_STAGE_OUT  3'd5
`define NN_STAGE_POST 3'd6
`define NN_STAGE_NONE 3'd7        // Idle, or no flag recorded

`endif

//--- hw/nn_top.sv
`default_nettype none
`timescale 1ns/1ps

module nn_top (
    input  logic          clk,
    input  logic          resetn,
    input  logic          enable,
    input  nn_pkg::data_t input_1,
    input  nn_pkg::data_t input_2,
    output nn_pkg::data_t final_output,
    output logic          total_ovf,
    output logic          total_zero,
    output logic [2:0]    ovf_fsm_stage,
    output logic [2:0]    zero_fsm_stage
);

    nn_pkg::stage_t stage;          // Current sequencer stage
    logic           out_step;       // Output layer serial step
    logic           start;          // First cycle of a run
    logic           stage_ovf;      // Also the abort request
    logic           stage_zero;
    nn_pkg::data_t  post_result;

    nn_decode u_decode (
        .clk       (clk),
        .resetn    (resetn),
        .enable    (enable),
        .stage_ovf (stage_ovf),
        .stage     (stage),
        .out_step  (out_step),
        .start     (start)
    );

    nn_execute u_execute (
        .clk         (clk),
        .resetn      (resetn),
        .stage       (stage),
        .out_step    (out_step),
        .input_1     (input_1),
        .input_2     (input_2),
        .stage_ovf   (stage_ovf),
        .stage_zero  (stage_zero),
        .post_result (post_result)
    );

    nn_result u_result (
        .clk(clk), .resetn(resetn), .stage(stage), .start(start),
        .stage_ovf(stage_ovf), .stage_zero(stage_zero), .post_result(post_result),
        .final_output(final_output), .total_ovf(total_ovf), .total_zero(total_zero),
        .ovf_fsm_stage(ovf_fsm_stage), .zero_fsm_stage(zero_fsm_stage)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f verilog.f --top-module nn_tb -o nn_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/nn_sim | tee /dev/stderr | grep "Testbench passed" > /dev/null \
    && { echo "Simulation PASS"; exit 0; } \
    || { echo "Simulation FAIL"; exit 1; }

//--- verif/nn_golden.txt
# input_1 input_2 final_output total_ovf total_zero ovf_fsm_stage zero_fsm_stage
# All columns hex, lines starting with # are skipped
# Normal runs
00000014 00000028 00000222 0 0 7 7
FFFFFF9C 00000040 00000042 0 0 7 7
FFFFFFFF FFFFFFFD FFFFFFE6 0 0 7 7
# Zero in pre-processing, later zeros keep stage 3
00000001 00000028 000001AA 0 1 7 3
00000014 00000003 00000092 0 1 7 3
# Input layer multiply overflow, then a clean run
7FFFFFFE 00000028 FFFFFFFF 1 0 4 7
00000014 00000028 00000222 0 0 7 7
# Output layer overflow, then overflow on top of a pre-processing zero
2AAAAAAC 00000028 FFFFFFFF 1 0 5 7
7FFFFFFE 00000001 FFFFFFFF 1 1 4 3
# Post-processing shift overflow, then clean runs
00000014 0CCCCCD0 FFFFFFFF 1 0 6 7
FFFFFF9C 00000040 00000042 0 0 7 7
00000001 00000028 000001AA 0 1 7 3

//--- verif/nn_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "nn_settings.svh"

module nn_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int RUN_WAIT     = 8;     // Worst case run is 5 cycles

    logic          clk;
    logic          resetn;
    logic          enable;
    nn_pkg::data_t input_1;
    nn_pkg::data_t input_2;
    nn_pkg::data_t final_output;
    logic          total_ovf;
    logic          total_zero;
    logic [2:0]    ovf_fsm_stage;
    logic [2:0]    zero_fsm_stage;

    // Golden columns, one entry per vector
    logic [31:0] gold_in_1[$];
    logic [31:0] gold_in_2[$];
    logic [31:0] gold_out[$];
    logic [31:0] gold_ovf[$];
    logic [31:0] gold_zero[$];
    logic [31:0] gold_ovf_stage[$];
    logic [31:0] gold_zero_stage[$];

    int error_count;
    int check_count;
    int vector_count;
    bit vectors_loaded;                  // Lets the watchdog size its limit

    nn_top u_nn_top (
        .clk            (clk),
        .resetn         (resetn),
        .enable         (enable),
        .input_1        (input_1),
        .input_2        (input_2),
        .final_output   (final_output),
        .total_ovf      (total_ovf),
        .total_zero     (total_zero),
        .ovf_fsm_stage  (ovf_fsm_stage),
        .zero_fsm_stage (zero_fsm_stage)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // Parse the golden file into the column queues
    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_in1, f_in2, f_out, f_ovf, f_zero, f_ovf_st, f_zero_st;
        fd = $fopen("verif/nn_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file verif/nn_golden.txt");
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line[0] != "#") begin   // Skip comments
                n = $sscanf(line, "%h %h %h %h %h %h %h",
                    f_in1, f_in2, f_out, f_ovf, f_zero, f_ovf_st, f_zero_st);
                if (n == 7) begin
                    gold_in_1.push_back(f_in1);
                    gold_in_2.push_back(f_in2);
                    gold_out.push_back(f_out);
                    gold_ovf.push_back(f_ovf);
                    gold_zero.push_back(f_zero);
                    gold_ovf_stage.push_back(f_ovf_st);
                    gold_zero_stage.push_back(f_zero_st);
                end
            end
        end
        $fclose(fd);
        vector_count = gold_in_1.size();
        if (vector_count == 0) begin
            $display("The golden file holds no vectors, nothing was tested");
            error_count++;
        end
    endtask

    // Compare one output field
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        value_match: assert (got === exp)
            else begin
                $display("Error at time %0d ns: %s is %h, expected %h",
                    $time, name, got, exp);
                error_count++;
            end
    endtask

    // All five outputs against one expected set
    task automatic check_outputs(input string tag, input logic [31:0] exp_out,
                                 input logic exp_ovf, input logic exp_zero,
                                 input logic [2:0] exp_ovf_stage,
                                 input logic [2:0] exp_zero_stage);
        check_value({tag, " final_output"}, final_output, exp_out);
        check_value({tag, " total_ovf"}, {31'b0, total_ovf}, {31'b0, exp_ovf});
        check_value({tag, " total_zero"}, {31'b0, total_zero}, {31'b0, exp_zero});
        check_value({tag, " ovf_fsm_stage"}, {29'b0, ovf_fsm_stage}, {29'b0, exp_ovf_stage});
        check_value({tag, " zero_fsm_stage"}, {29'b0, zero_fsm_stage},
            {29'b0, exp_zero_stage});
    endtask

    // Pulse enable once, let the run finish, compare
    task automatic run_vector(input int idx);
        string tag;
        tag = $sformatf("vector %0d", idx);
        @(negedge clk);
        input_1 = gold_in_1[idx];
        input_2 = gold_in_2[idx];        // Held until the next vector
        enable  = 1'b1;
        @(negedge clk);
        enable  = 1'b0;                  // Ignored once the run is going
        repeat (RUN_WAIT) @(negedge clk);
        check_outputs(tag, gold_out[idx], gold_ovf[idx][0], gold_zero[idx][0],
            gold_ovf_stage[idx][2:0], gold_zero_stage[idx][2:0]);
    endtask

    initial begin : main
        clk            = 1'b0;
        resetn         = 1'b0;
        enable         = 1'b0;
        input_1        = '0;
        input_2        = '0;
        error_count    = 0;
        check_count    = 0;
        vector_count   = 0;
        vectors_loaded = 1'b0;

        load_vectors();
        vectors_loaded = 1'b1;

        repeat (RESET_CYCLES) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        // Engine idle, nothing recorded yet
        check_outputs("after reset", '0, 1'b0, 1'b0, `NN_STAGE_NONE, `NN_STAGE_NONE);

        for (int i = 0; i < vector_count; i++) begin
            run_vector(i);
        end

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Ten cycles per vector plus room for reset
    initial begin : watchdog
        int limit;
        wait (vectors_loaded);
        limit = vector_count * 10 + 20;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+hw
hw/nn_pkg.sv
hw/nn_alu.sv
hw/nn_mac.sv
hw/nn_decode.sv
hw/nn_execute.sv
hw/nn_result.sv
hw/nn_top.sv
verif/nn_tb.sv
